/* flitFifo.sv */
`timescale 1ns/1ps
`default_nettype none

module flitFifo
(
  input  logic             clk,
  input  logic             rst,
  input  routerPkg::flit_t inFlit,
  input  logic             inValid,
  output logic             inReady,
  input  logic             pop,
  output routerPkg::flit_t headFlit,
  output logic             notEmpty
);

  import routerPkg::*;

  flit_t mem [FIFO_DEPTH];
  logic [FIFO_PTR_W-1:0] wrPtr;
  logic [FIFO_PTR_W-1:0] rdPtr;
  logic [FIFO_CNT_W-1:0] count;
  logic push;

  function automatic logic [FIFO_PTR_W-1:0] nextPtr(input logic [FIFO_PTR_W-1:0] ptr);
    if (ptr == FIFO_PTR_W'(FIFO_DEPTH - 1))
      return '0;
    return ptr + 1'b1;
  endfunction

  assign inReady = count != FIFO_CNT_W'(FIFO_DEPTH);
  assign notEmpty = count != '0;
  assign push = inValid && inReady;

  // The head is read straight from the array, so a push shows up one cycle later
  assign headFlit = mem[rdPtr];

  always_ff @(posedge clk)
  begin
    if (push)
    begin
      mem[wrPtr] <= inFlit;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (push)
      begin
        wrPtr <= nextPtr(wrPtr);
      end
      if (pop)
      begin
        rdPtr <= nextPtr(rdPtr);
      end
      case ({push, pop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // The link stage must only pop a buffer that holds a flit
  popNotEmpty: assert property (@(posedge clk) disable iff (rst) pop |-> notEmpty)
    else $error("flitFifo popped while empty");

endmodule

`default_nettype wire

/* outputArbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module outputArbiter
(
  input  logic                            clk,
  input  logic                            rst,
  input  logic [routerPkg::NUM_PORTS-1:0] req,
  input  routerPkg::flit_t                popFlit,
  input  logic [routerPkg::NUM_PORTS-1:0] pop,
  output routerPkg::grant_t               grant
);

  import routerPkg::*;

  grant_t grantNext;
  logic [NUM_PORTS-1:0] advance;
  logic [NUM_PORTS-1:0] timesUp;

  // Scans span ports starting at first, wrapping in L, N, E, W, S order
  function automatic grant_t pickPort(input logic [NUM_PORTS-1:0] reqs, input int first,
                                      input int span);
    grant_t pick;
    int k;
    int idx;
    pick = GRANT_IDLE;
    for (k = span - 1; k >= 0; k--)
    begin
      idx = (first + k) % NUM_PORTS;
      if (reqs[idx])
        pick = grant_t'(1) << (idx + 1);
    end
    return pick;
  endfunction

  // Only the port holding the grant counts its popped flits
  assign advance = pop & grant[NUM_PORTS:1];

  for (genvar i = 0; i < NUM_PORTS; i++)
  begin : gTimer
    packetTimer uTimer
    (
      .clk     (clk),
      .rst     (rst),
      .popFlit (popFlit),
      .advance (advance[i]),
      .timesUp (timesUp[i])
    );
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      grant <= GRANT_IDLE;
    else
      grant <= grantNext;
  end

  // A granted port keeps the channel even with an empty buffer until its
  // packet is complete, then the search starts at the next port in turn
  always_comb
  begin
    case (grant)
      GRANT_IDLE:
        grantNext = pickPort(req, int'(PORT_L), NUM_PORTS);
      GRANT_L:
        grantNext = timesUp[PORT_L] ? pickPort(req, int'(PORT_N), NUM_PORTS - 1) : GRANT_L;
      GRANT_N:
        grantNext = timesUp[PORT_N] ? pickPort(req, int'(PORT_E), NUM_PORTS - 1) : GRANT_N;
      GRANT_E:
        grantNext = timesUp[PORT_E] ? pickPort(req, int'(PORT_W), NUM_PORTS - 1) : GRANT_E;
      GRANT_W:
        grantNext = timesUp[PORT_W] ? pickPort(req, int'(PORT_S), NUM_PORTS - 1) : GRANT_W;
      GRANT_S:
        grantNext = timesUp[PORT_S] ? pickPort(req, int'(PORT_L), NUM_PORTS - 1) : GRANT_S;
      default:
        grantNext = GRANT_IDLE;
    endcase
  end

  grantOneHot: assert property (@(posedge clk) disable iff (rst) $onehot(grant))
    else $error("outputArbiter grant is not one-hot");

endmodule

`default_nettype wire

/* outputLink.sv */
`timescale 1ns/1ps
`default_nettype none

module outputLink
(
  input  logic                            clk,
  input  logic                            rst,
  input  routerPkg::grant_t               grant,
  input  routerPkg::flit_t                headFlits [routerPkg::NUM_PORTS],
  input  logic [routerPkg::NUM_PORTS-1:0] notEmpty,
  output logic [routerPkg::NUM_PORTS-1:0] pop,
  output routerPkg::flit_t                outFlit,
  output logic                            outValid,
  input  logic                            outReady
);

  import routerPkg::*;

  logic [NUM_PORTS-1:0] portSel;
  flit_t selFlit;
  logic selNotEmpty;
  logic outRegFree;

  assign portSel = grant[NUM_PORTS:1];

  always_comb
  begin
    selFlit = '0;
    selNotEmpty = 1'b0;
    for (int i = 0; i < NUM_PORTS; i++)
    begin
      if (portSel[i])
      begin
        selFlit = headFlits[i];
        selNotEmpty = notEmpty[i];
      end
    end
  end

  // The register can take a flit when it is empty or drains this cycle
  assign outRegFree = !outValid || outReady;
  assign pop = (outRegFree && selNotEmpty) ? portSel : '0;

  always_ff @(posedge clk)
  begin
    if (rst)
      outValid <= 1'b0;
    else if (outRegFree)
      outValid <= |pop;
  end

  always_ff @(posedge clk)
  begin
    if (|pop)
    begin
      outFlit <= selFlit;
    end
  end

  holdUnderStall: assert property (@(posedge clk) disable iff (rst)
    outValid && !outReady |=> outValid && $stable(outFlit))
    else $error("outputLink changed outFlit while stalled");

endmodule

`default_nettype wire

/* packetTimer.sv */
`timescale 1ns/1ps
`default_nettype none

module packetTimer
(
  input  logic             clk,
  input  logic             rst,
  input  routerPkg::flit_t popFlit,
  input  logic             advance,
  output logic             timesUp
);

  import routerPkg::*;

  logic [LEN_W-1:0] length;
  logic [LEN_W-1:0] count;
  logic isHead;
  logic isBody;

  assign isHead = popFlit.flitId == FLIT_HEAD;
  assign isBody = popFlit.flitId == FLIT_BODY;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      length <= '0;
      count <= '0;
    end
    else if (advance && isHead)
    begin
      length <= popFlit.body.header.length;
      count <= LEN_W'(1);
    end
    else if (advance && isBody)
    begin
      count <= count + 1'b1;
    end
  end

  // High during the pop of the last flit; a length of 0 or 1 is a lone header
  always_comb
  begin
    if (!advance)
      timesUp = 1'b0;
    else if (isHead)
      timesUp = popFlit.body.header.length <= LEN_W'(1);
    else
      timesUp = isBody && (LEN_W'(count + 1'b1) == length);
  end

endmodule

`default_nettype wire

/* routerOutputPort.f */
routerPkg.sv
flitFifo.sv
packetTimer.sv
outputArbiter.sv
outputLink.sv
routerOutputPort.sv
tbRouterOutputPort.sv

/* routerOutputPort.sv */
`timescale 1ns/1ps
`default_nettype none

module routerOutputPort
(
  input  logic                            clk,
  input  logic                            rst,
  input  routerPkg::flit_t                inFlit [routerPkg::NUM_PORTS],
  input  logic [routerPkg::NUM_PORTS-1:0] inValid,
  output logic [routerPkg::NUM_PORTS-1:0] inReady,
  output routerPkg::flit_t                outFlit,
  output logic                            outValid,
  input  logic                            outReady
);

  import routerPkg::*;

  flit_t headFlits [NUM_PORTS];
  flit_t popFlit;
  logic [NUM_PORTS-1:0] notEmpty;
  logic [NUM_PORTS-1:0] pop;
  grant_t grant;

  for (genvar i = 0; i < NUM_PORTS; i++)
  begin : gBuffer
    flitFifo uFifo
    (
      .clk      (clk),
      .rst      (rst),
      .inFlit   (inFlit[i]),
      .inValid  (inValid[i]),
      .inReady  (inReady[i]),
      .pop      (pop[i]),
      .headFlit (headFlits[i]),
      .notEmpty (notEmpty[i])
    );
  end

  // Pop is one-hot, so the timers see the head of whichever buffer is popped
  always_comb
  begin
    popFlit = '0;
    for (int i = 0; i < NUM_PORTS; i++)
    begin
      if (pop[i])
        popFlit = headFlits[i];
    end
  end

  outputArbiter uArbiter
  (
    .clk     (clk),
    .rst     (rst),
    .req     (notEmpty),
    .popFlit (popFlit),
    .pop     (pop),
    .grant   (grant)
  );

  outputLink uLink
  (
    .clk       (clk),
    .rst       (rst),
    .grant     (grant),
    .headFlits (headFlits),
    .notEmpty  (notEmpty),
    .pop       (pop),
    .outFlit   (outFlit),
    .outValid  (outValid),
    .outReady  (outReady)
  );

endmodule

`default_nettype wire

/* routerOutputPort_testdata.txt */
// Columns: test, input port (0 L, 1 N, 2 E, 3 W, 4 S), length in flits, destination,
// then one data word per body flit; all hex, and the list ends with ffff
2 3 3 9 a301 a302
3 0 2 1 b001
3 1 3 2 b101 b102
3 2 4 3 b201 b202 b203
3 3 2 4 b301
3 4 3 5 b401 b402
4 2 4 3 c201 c202 c203
4 0 2 1 c001
4 3 3 4 c301 c302
5 1 3 2 d101 d102
5 1 4 2 d111 d112 d113
5 4 3 5 d401 d402
5 4 2 5 d411
6 0 5 1 e001 e002 e003 e004
6 0 2 1 e011
6 1 3 2 e101 e102
6 1 6 2 e111 e112 e113 e114 e115
6 2 4 3 e201 e202 e203
6 2 2 3 e211
6 3 7 4 e301 e302 e303 e304 e305 e306
6 3 3 4 e311 e312
6 4 2 5 e401
6 4 5 5 e411 e412 e413 e414
6 4 3 5 e421 e422
ffff

/* routerPkg.sv */
`default_nettype none

package routerPkg;

  localparam int NUM_PORTS = 5;
  localparam int FIFO_DEPTH = 4;
  localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
  localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

  localparam int LEN_W = 12;
  localparam int DEST_W = 4;
  localparam int DATA_W = LEN_W + DEST_W;

  // Flit identifiers carried in the top three bits of every flit
  localparam logic [2:0] FLIT_HEAD = 3'b001;
  localparam logic [2:0] FLIT_BODY = 3'b010;

  typedef struct packed
  {
    logic [LEN_W-1:0] length;
    logic [DEST_W-1:0] dest;
  } headerFields_t;

  // The length counts every flit of the packet, the header included
  typedef union packed
  {
    headerFields_t header;
    logic [DATA_W-1:0] data;
  } flitBody_u;

  typedef struct packed
  {
    logic [2:0] flitId;
    flitBody_u body;
  } flit_t;

  typedef enum logic [2:0]
  {
    PORT_L = 3'd0,
    PORT_N = 3'd1,
    PORT_E = 3'd2,
    PORT_W = 3'd3,
    PORT_S = 3'd4
  } portIdx_t;

  // Bit 0 is idle, bits 1 to 5 grant L, N, E, W and S
  typedef logic [NUM_PORTS:0] grant_t;

  localparam grant_t GRANT_IDLE = 6'b000001;
  localparam grant_t GRANT_L = 6'b000010;
  localparam grant_t GRANT_N = 6'b000100;
  localparam grant_t GRANT_E = 6'b001000;
  localparam grant_t GRANT_W = 6'b010000;
  localparam grant_t GRANT_S = 6'b100000;

endpackage

`default_nettype wire

/* run.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and scans the log for failure
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f routerOutputPort.f \
  --top-module tbRouterOutputPort -o simv
./obj_dir/simv | tee sim.log

if grep -q "TEST FAILED" sim.log; then
  exit 1
fi
if ! grep -q "TEST PASSED" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi

/* tbRouterOutputPort.sv */
`timescale 1ns/1ps
`default_nettype none

module tbRouterOutputPort;

  import routerPkg::*;

  localparam int NUM_TESTS = 6;
  localparam int MAX_WORDS = 512;

  logic clk;
  logic rst;
  flit_t inFlit [NUM_PORTS];
  logic [NUM_PORTS-1:0] inValid;
  logic [NUM_PORTS-1:0] inReady;
  flit_t outFlit;
  logic outValid;
  logic outReady;

  logic [15:0] words [MAX_WORDS];
  flit_t srcQ [(NUM_TESTS + 1) * NUM_PORTS][$];
  flit_t drvQ [NUM_PORTS][$];
  flit_t expQ [NUM_PORTS][$];
  int orderSeen [$];
  int orderWant [$];
  logic [NUM_PORTS-1:0] portEnable;
  logic randomReady;
  logic [31:0] rngState;
  int errors;
  int testsRun;
  int testsFailed;
  int totalFlits;
  int received;
  int curPort;
  int remaining;
  int watchCycles;
  string testName;

  routerOutputPort dut
  (
    .clk      (clk),
    .rst      (rst),
    .inFlit   (inFlit),
    .inValid  (inValid),
    .inReady  (inReady),
    .outFlit  (outFlit),
    .outValid (outValid),
    .outReady (outReady)
  );

  always #2 clk = ~clk;

  initial
  begin
    wait (watchCycles != 0);
    #(watchCycles * 4);
    $display("Watchdog expired: the tests did not finish within %0d cycles", watchCycles);
    $display("TEST FAILED");
    $finish;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic checkValue(input string what, input logic [31:0] expected,
                            input logic [31:0] actual);
    if (expected !== actual)
    begin
      $display("Error %s, %s: expected %h actual %h", testName, what, expected, actual);
      errors++;
    end
  endtask

  task automatic reportProblem(input string msg);
    $display("%s: %s", testName, msg);
    errors++;
  endtask

  // Each record is test, port, length, destination and length-1 data words
  task automatic loadTestData();
    int pos;
    int t;
    int p;
    int len;
    int k;
    flit_t f;
    for (pos = 0; pos < MAX_WORDS; pos++)
    begin
      words[pos] = 16'hffff;
    end
    $readmemh("routerOutputPort_testdata.txt", words);
    pos = 0;
    totalFlits = 0;
    while (words[pos] != 16'hffff)
    begin
      t = int'(words[pos]);
      p = int'(words[pos + 1]);
      len = int'(words[pos + 2]);
      f = '0;
      f.flitId = FLIT_HEAD;
      f.body.header.length = len[LEN_W-1:0];
      f.body.header.dest = words[pos + 3][DEST_W-1:0];
      srcQ[t * NUM_PORTS + p].push_back(f);
      pos += 4;
      for (k = 1; k < len; k++)
      begin
        f.flitId = FLIT_BODY;
        f.body.data = words[pos];
        srcQ[t * NUM_PORTS + p].push_back(f);
        pos++;
      end
      totalFlits += len;
    end
  endtask

  // A header is tied to its port by matching the next pending packet of every port
  task automatic consumeFlit(input flit_t f);
    int p;
    int found;
    found = -1;
    received++;
    if (f.flitId == FLIT_HEAD)
    begin
      if (remaining != 0)
        reportProblem($sformatf("header %h interleaved into a packet of port %0d", f, curPort));
      for (p = NUM_PORTS - 1; p >= 0; p--)
      begin
        if (expQ[p].size() != 0 && expQ[p][0] == f)
          found = p;
      end
      if (found < 0)
      begin
        reportProblem($sformatf("header %h matches no pending packet", f));
        remaining = 0;
      end
      else
      begin
        curPort = found;
        void'(expQ[found].pop_front());
        remaining = int'(f.body.header.length) - 1;
        orderSeen.push_back(found);
      end
    end
    else if (remaining == 0)
      reportProblem($sformatf("body flit %h arrived outside any packet", f));
    else
    begin
      checkValue($sformatf("port %0d flit", curPort), 32'(expQ[curPort].pop_front()), 32'(f));
      remaining--;
    end
  endtask

  // Inputs change on the falling edge, where inReady and outValid are settled
  task automatic cycleStep();
    int p;
    @(negedge clk);
    rngState = xorshift(rngState);
    outReady = randomReady ? rngState[4] : 1'b1;
    if (outValid && outReady)
      consumeFlit(outFlit);
    for (p = 0; p < NUM_PORTS; p++)
    begin
      rngState = xorshift(rngState);
      inValid[p] = 1'b0;
      if (portEnable[p] && drvQ[p].size() != 0 && !(randomReady && rngState[2:1] == 2'b00))
      begin
        inFlit[p] = drvQ[p][0];
        inValid[p] = 1'b1;
        if (inReady[p])
          void'(drvQ[p].pop_front());
      end
    end
  endtask

  task automatic finishTest(input int startErrors);
    testsRun++;
    if (errors == startErrors)
      $display("test %s: passed", testName);
    else
    begin
      $display("test %s: failed with %0d errors", testName, errors - startErrors);
      testsFailed++;
    end
  endtask

  task automatic runTest(input int t, input string name);
    int p;
    int k;
    int expected;
    int startErrors;
    testName = name;
    startErrors = errors;
    expected = 0;
    received = 0;
    remaining = 0;
    orderSeen.delete();
    for (p = 0; p < NUM_PORTS; p++)
    begin
      drvQ[p] = srcQ[t * NUM_PORTS + p];
      expQ[p] = srcQ[t * NUM_PORTS + p];
      expected += srcQ[t * NUM_PORTS + p].size();
    end
    portEnable = (t == 4) ? 5'b00100 : 5'b11111;
    randomReady = t == 6;
    while (received < expected)
    begin
      cycleStep();
      // Local and West join once the East header is on the link
      if (t == 4 && orderSeen.size() != 0)
        portEnable = 5'b11111;
    end
    randomReady = 1'b0;
    repeat (6)
      cycleStep();
    for (p = 0; p < NUM_PORTS; p++)
    begin
      checkValue($sformatf("port %0d flits missing", p), 32'h0, 32'(expQ[p].size()));
    end
    if (orderWant.size() != 0)
    begin
      checkValue("packet count", 32'(orderWant.size()), 32'(orderSeen.size()));
      for (k = 0; k < orderWant.size() && k < orderSeen.size(); k++)
      begin
        checkValue($sformatf("port of packet %0d", k), 32'(orderWant[k]), 32'(orderSeen[k]));
      end
    end
    finishTest(startErrors);
  endtask

  initial
  begin
    clk = 1'b0;
    rst = 1'b1;
    inValid = '0;
    outReady = 1'b1;
    for (int p = 0; p < NUM_PORTS; p++)
    begin
      inFlit[p] = '0;
    end
    portEnable = '0;
    randomReady = 1'b0;
    rngState = 32'd62460;
    errors = 0;
    testsRun = 0;
    testsFailed = 0;
    curPort = 0;
    remaining = 0;
    watchCycles = 0;
    loadTestData();
    watchCycles = totalFlits * 40 + 200;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    testName = "idle after reset";
    repeat (8)
    begin
      cycleStep();
      checkValue("outValid", 32'h0, 32'(outValid));
      checkValue("inReady", 32'h1f, 32'(inReady));
    end
    finishTest(0);

    orderWant = {};
    runTest(2, "single packet on West");
    orderWant = {int'(PORT_L), int'(PORT_N), int'(PORT_E), int'(PORT_W), int'(PORT_S)};
    runTest(3, "all ports at once");
    orderWant = {int'(PORT_E), int'(PORT_W), int'(PORT_L)};
    runTest(4, "rotation from East");
    orderWant = {int'(PORT_N), int'(PORT_S), int'(PORT_N), int'(PORT_S)};
    runTest(5, "North and South streaming");
    orderWant = {};
    runTest(6, "random back-pressure");

    $display("%0d tests run, %0d failed, %0d errors", testsRun, testsFailed, errors);
    if (errors == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire
